//--- source/shifter_pkg.sv
package shifter_pkg;

    ////////////////////
    // data path widths
    ////////////////////

    // switch word fed into the shifter
    parameter int DATA_W = 16;

    // four stages of 1, 2, 4 and 8
    parameter int SHAMT_W = 4;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    ////////////////////
    // display
    ////////////////////

    // segments a..g on bits 0..6, low = lit
    typedef logic [6:0] seg_t;

    // digits on the board, one anode each
    parameter int NUM_DIGITS = 8;

    // all segments dark
    parameter seg_t SEG_BLANK = 7'h7f;

endpackage

//--- source/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter int TICK_DIV = 100_000
) (
    input  logic clk_demo,
    input  logic arst_n,
    output logic tick
);

    // keep at least one bit when the divider is 1
    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] count;

    // wrapping divider, tick registered on the wrap
    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == CNT_W'(TICK_DIV - 1)) begin
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // a real divider never gives back-to-back ticks
    tick_single_cycle_a: assert property (
        @(posedge clk_demo) disable iff (!arst_n)
        (TICK_DIV > 1) && tick |=> !tick
    );

endmodule

//--- source/button_debounce.sv
`timescale 1ns/1ps

module button_debounce #(
    parameter int DEBOUNCE_TICKS = 10
) (
    input  logic clk_demo,
    input  logic arst_n,
    input  logic tick,
    input  logic btn_raw,
    output logic press,
    output logic toggle
);

    localparam int CNT_W = $clog2(DEBOUNCE_TICKS + 1);

    logic             sync_q1;
    logic             sync_q2;
    logic             level;
    logic [CNT_W-1:0] stable_cnt;

    ////////////////////
    // synchronizer
    ////////////////////

    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= btn_raw;
            sync_q2 <= sync_q1;
        end
    end

    ////////////////////
    // level tracker
    ////////////////////

    // counts ticks spent away from the accepted level;
    // any bounce back to it restarts the count
    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            level      <= 1'b0;
            stable_cnt <= '0;
            press      <= 1'b0;
            toggle     <= 1'b0;
        end else begin
            press <= 1'b0;
            if (sync_q2 == level) begin
                stable_cnt <= '0;
            end else if (tick) begin
                if (stable_cnt == CNT_W'(DEBOUNCE_TICKS - 1)) begin
                    stable_cnt <= '0;
                    level      <= sync_q2;
                    // only a rising edge counts as a press
                    press      <= sync_q2;
                    toggle     <= toggle ^ sync_q2;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- source/shift_control.sv
`timescale 1ns/1ps

module shift_control
    import shifter_pkg::*;
(
    input  logic       clk_demo,
    input  logic       arst_n,
    input  logic       dir_toggle,
    input  logic       rot_toggle,
    input  logic       s0_toggle,
    input  logic       s1_toggle,
    input  logic       hi_press,
    output logic       dir,
    output logic       rotate,
    output shamt_t     shamt,
    output logic [1:0] shamt_hi
);

    logic       s0_q;
    logic       s1_q;
    logic [1:0] hi_cnt;

    ////////////////////
    // settings
    ////////////////////

    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            dir    <= 1'b0;
            rotate <= 1'b0;
            s0_q   <= 1'b0;
            s1_q   <= 1'b0;
            hi_cnt <= 2'd0;
        end else begin
            dir    <= dir_toggle;
            rotate <= rot_toggle;
            s0_q   <= s0_toggle;
            s1_q   <= s1_toggle;
            // wraps 3 -> 0
            if (hi_press) begin
                hi_cnt <= hi_cnt + 2'd1;
            end
        end
    end

    // high counter sits above the two toggled bits
    assign shamt    = {hi_cnt, s1_q, s0_q};
    assign shamt_hi = hi_cnt;

    ////////////////////
    // checks
    ////////////////////

    hi_changes_on_press_a: assert property (
        @(posedge clk_demo) disable iff (!arst_n)
        !$stable(shamt_hi) |-> $past(hi_press)
    );

    hi_steps_by_one_a: assert property (
        @(posedge clk_demo) disable iff (!arst_n)
        hi_press |=> shamt_hi == 2'($past(shamt_hi) + 2'd1)
    );

endmodule

//--- source/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter
    import shifter_pkg::*;
(
    input  logic   clk_demo,
    input  logic   arst_n,
    input  data_t  din,
    input  shamt_t shamt,
    input  logic   dir,
    input  logic   rotate,
    output data_t  dout
);

    // stage[0] is the input, stage[SHAMT_W] the fully shifted word
    data_t stage [0:SHAMT_W];

    assign stage[0] = din;

    ////////////////////
    // log shifter
    ////////////////////

    for (genvar k = 0; k < SHAMT_W; k++) begin : g_stage
        localparam int N = 1 << k;

        data_t fill;
        data_t moved;

        always_comb begin
            // dir 1 is left, dir 0 is right
            if (dir) begin
                moved = stage[k] << N;
                fill  = data_t'(stage[k] >> (DATA_W - N));
            end else begin
                moved = stage[k] >> N;
                fill  = data_t'(stage[k] << (DATA_W - N));
            end
            // logical shift leaves the vacated bits at zero
            stage[k+1] = !shamt[k] ? stage[k] : (rotate ? (moved | fill) : moved);
        end
    end

    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            dout <= '0;
        end else begin
            dout <= stage[SHAMT_W];
        end
    end

    // rotate only moves bits around
    rotate_keeps_ones_a: assert property (
        @(posedge clk_demo) disable iff (!arst_n)
        rotate |=> $countones(dout) == $countones($past(din))
    );

endmodule

//--- source/seg_display.sv
`timescale 1ns/1ps

module seg_display
    import shifter_pkg::*;
(
    input  logic                  clk_demo,
    input  logic                  arst_n,
    input  logic                  tick,
    input  data_t                 result,
    input  logic [1:0]            shamt_hi,
    output seg_t                  seg,
    output logic [NUM_DIGITS-1:0] an
);

    localparam int IDX_W = $clog2(NUM_DIGITS);

    logic [IDX_W-1:0] digit_idx;
    logic [IDX_W-1:0] next_idx;
    logic [3:0]       nibble;
    logic             blank;

    ////////////////////
    // digit source
    ////////////////////

    assign next_idx = digit_idx + 1'b1;

    always_comb begin
        nibble = 4'h0;
        blank  = 1'b0;
        case (next_idx)
            3'd0: nibble = result[3:0];
            3'd1: nibble = result[7:4];
            3'd2: nibble = result[11:8];
            3'd3: nibble = result[15:12];
            3'd4: nibble = {2'b00, shamt_hi};
            default: blank = 1'b1;
        endcase
    end

    // active low, a on bit 0
    function automatic seg_t hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    ////////////////////
    // scan
    ////////////////////

    // index parks on the last digit so the first tick lands on digit 0
    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            digit_idx <= IDX_W'(NUM_DIGITS - 1);
            an        <= '1;
            seg       <= SEG_BLANK;
        end else if (tick) begin
            digit_idx <= next_idx;
            an        <= ~(NUM_DIGITS'(1) << next_idx);
            seg       <= blank ? SEG_BLANK : hex_to_seg(nibble);
        end
    end

    an_one_cold_a: assert property (
        @(posedge clk_demo) disable iff (!arst_n)
        $onehot(~an) || (&an)
    );

endmodule

//--- source/shifter_board_top.sv
`timescale 1ns/1ps

module shifter_board_top
    import shifter_pkg::*;
#(
    parameter int TICK_DIV       = 100_000,
    parameter int DEBOUNCE_TICKS = 10
) (
    input  logic       clk_demo,
    input  logic       arst_n,
    input  data_t      sw,
    input  logic [4:0] btn,
    output logic [7:0] led,
    output seg_t       seg,
    output logic [7:0] an
);

    logic       tick;
    logic       dir_toggle;
    logic       rot_toggle;
    logic       s0_toggle;
    logic       s1_toggle;
    logic       hi_press;
    logic       dir;
    logic       rotate;
    shamt_t     shamt;
    logic [1:0] shamt_hi;
    data_t      result;

    tick_gen #(.TICK_DIV(TICK_DIV)) tick_gen_i (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick)
    );

    ////////////////////
    // buttons
    ////////////////////

    // btn 4..1 toggle settings, btn 0 steps the high count
    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) db_dir_i (
        .clk_demo (clk_demo), .arst_n (arst_n), .tick (tick),
        .btn_raw  (btn[4]), .press (), .toggle (dir_toggle)
    );
    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) db_rot_i (
        .clk_demo (clk_demo), .arst_n (arst_n), .tick (tick),
        .btn_raw  (btn[3]), .press (), .toggle (rot_toggle)
    );
    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) db_s0_i (
        .clk_demo (clk_demo), .arst_n (arst_n), .tick (tick),
        .btn_raw  (btn[2]), .press (), .toggle (s0_toggle)
    );
    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) db_s1_i (
        .clk_demo (clk_demo), .arst_n (arst_n), .tick (tick),
        .btn_raw  (btn[1]), .press (), .toggle (s1_toggle)
    );
    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) db_hi_i (
        .clk_demo (clk_demo), .arst_n (arst_n), .tick (tick),
        .btn_raw  (btn[0]), .press (hi_press), .toggle ()
    );

    ////////////////////
    // control and data path
    ////////////////////

    shift_control shift_control_i (
        .clk_demo   (clk_demo),
        .arst_n     (arst_n),
        .dir_toggle (dir_toggle),
        .rot_toggle (rot_toggle),
        .s0_toggle  (s0_toggle),
        .s1_toggle  (s1_toggle),
        .hi_press   (hi_press),
        .dir        (dir),
        .rotate     (rotate),
        .shamt      (shamt),
        .shamt_hi   (shamt_hi)
    );

    barrel_shifter barrel_shifter_i (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .din      (sw),
        .shamt    (shamt),
        .dir      (dir),
        .rotate   (rotate),
        .dout     (result)
    );

    seg_display seg_display_i (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick),
        .result   (result),
        .shamt_hi (shamt_hi),
        .seg      (seg),
        .an       (an)
    );

    // shamt on the top four, two spare leds dark
    assign led = {shamt, rotate, dir, 2'b00};

endmodule

//--- dv/shifter_board_tb.sv
`timescale 1ns/1ps

module shifter_board_tb
    import shifter_pkg::*;
();

    localparam int TICK_DIV       = 4;
    localparam int DEBOUNCE_TICKS = 3;
    localparam int CLK_PERIOD     = 40;

    // run length estimate, used by the watchdog
    localparam int PRESS_CYCLES = 16 * TICK_DIV;
    localparam int SCAN_CYCLES  = 2 * NUM_DIGITS * TICK_DIV + 2;
    localparam int NUM_PRESSES  = 8 + 4 + 5 + 2 * 32 * 7;
    localparam int NUM_SCANS    = 1 + 4 + 2 * 32 * 40;
    localparam int TEST_CYCLES  = 10 + NUM_PRESSES * PRESS_CYCLES + NUM_SCANS * SCAN_CYCLES;

    logic       clk_demo;
    logic       arst_n;
    data_t      sw;
    logic [4:0] btn;
    logic [7:0] led;
    seg_t       seg;
    logic [7:0] an;

    int   seed = 19278;
    int   digit_val [NUM_DIGITS];

    // expected control state
    logic       exp_dir;
    logic       exp_rot;
    logic       exp_s0;
    logic       exp_s1;
    logic [1:0] exp_hi;

    shifter_board_top #(
        .TICK_DIV       (TICK_DIV),
        .DEBOUNCE_TICKS (DEBOUNCE_TICKS)
    ) shifter_board_top_i (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .sw       (sw),
        .btn      (btn),
        .led      (led),
        .seg      (seg),
        .an       (an)
    );

    always #(CLK_PERIOD / 2) clk_demo = ~clk_demo;

    ////////////////////
    // reference model
    ////////////////////

    // one bit per step, left when dir is 1
    function automatic data_t shift_ref(data_t d, int amt, logic left, logic rot);
        data_t r;
        r = d;
        for (int i = 0; i < amt; i++) begin
            if (left) begin
                r = {r[DATA_W-2:0], rot ? r[DATA_W-1] : 1'b0};
            end else begin
                r = {rot ? r[0] : 1'b0, r[DATA_W-1:1]};
            end
        end
        return r;
    endfunction

    function automatic logic [7:0] expected_led();
        return {exp_hi, exp_s1, exp_s0, exp_rot, exp_dir, 2'b00};
    endfunction

    // 0..15 for hex, 16 for blank, -1 for anything else
    function automatic int seg_to_hex(seg_t s);
        case (s)
            7'h40: return 0;
            7'h79: return 1;
            7'h24: return 2;
            7'h30: return 3;
            7'h19: return 4;
            7'h12: return 5;
            7'h02: return 6;
            7'h78: return 7;
            7'h00: return 8;
            7'h10: return 9;
            7'h08: return 10;
            7'h03: return 11;
            7'h46: return 12;
            7'h21: return 13;
            7'h06: return 14;
            7'h0e: return 15;
            7'h7f: return 16;
            default: return -1;
        endcase
    endfunction

    ////////////////////
    // checking
    ////////////////////

    task automatic fail_stop(string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_stop($sformatf("check of %s failed at %0t", name, $time));
        end
    endtask

    // one full scan; the last pattern seen on each digit wins
    task automatic scan_display();
        int code;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            digit_val[i] = -2;
        end
        repeat (NUM_DIGITS * TICK_DIV) begin
            @(negedge clk_demo);
            for (int i = 0; i < NUM_DIGITS; i++) begin
                if (an == ~(8'(1) << i)) begin
                    code = seg_to_hex(seg);
                    if (code < 0) begin
                        fail_stop($sformatf("unknown segment pattern 0x%0h on digit %0d",
                                            seg, i));
                    end
                    digit_val[i] = code;
                end
            end
        end
    endtask

    task automatic check_display(data_t exp_result, logic [1:0] hi);
        repeat (NUM_DIGITS * TICK_DIV + 2) @(negedge clk_demo);
        scan_display();
        for (int i = 0; i < 4; i++) begin
            check_value($sformatf("digit %0d", i), digit_val[i], exp_result[4*i +: 4]);
        end
        check_value("digit 4", digit_val[4], hi);
        for (int i = 5; i < NUM_DIGITS; i++) begin
            check_value($sformatf("digit %0d", i), digit_val[i], 16);
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic press_button(int b);
        @(negedge clk_demo);
        btn[b] = 1'b1;
        repeat (8 * TICK_DIV) @(negedge clk_demo);
        btn[b] = 1'b0;
        repeat (8 * TICK_DIV) @(negedge clk_demo);
        case (b)
            4: exp_dir = ~exp_dir;
            3: exp_rot = ~exp_rot;
            2: exp_s0  = ~exp_s0;
            1: exp_s1  = ~exp_s1;
            default: exp_hi = exp_hi + 2'd1;
        endcase
        check_value("led", led, expected_led());
    endtask

    // too short to pass the debouncer
    task automatic short_pulse(int b);
        @(negedge clk_demo);
        btn[b] = 1'b1;
        repeat ((DEBOUNCE_TICKS - 1) * TICK_DIV) @(negedge clk_demo);
        btn[b] = 1'b0;
        repeat (8 * TICK_DIV) @(negedge clk_demo);
        check_value("led", led, expected_led());
    endtask

    task automatic set_controls(logic d, logic r, logic [3:0] a);
        if (exp_dir != d) press_button(4);
        if (exp_rot != r) press_button(3);
        if (exp_s0 != a[0]) press_button(2);
        if (exp_s1 != a[1]) press_button(1);
        while (exp_hi != a[3:2]) begin
            press_button(0);
        end
    endtask

    task automatic sweep_mode(logic rot);
        for (int d = 0; d < 2; d++) begin
            for (int a = 0; a < 16; a++) begin
                set_controls(d[0], rot, a[3:0]);
                for (int w = 0; w < 40; w++) begin
                    @(negedge clk_demo);
                    sw = data_t'($random(seed));
                    check_display(shift_ref(sw, a, d[0], rot), exp_hi);
                end
            end
        end
    endtask

    initial begin
        #(2.0 * TEST_CYCLES * CLK_PERIOD);
        fail_stop("timeout: the tests did not finish in the expected time");
    end

    initial begin
        clk_demo = 1'b0;
        arst_n   = 1'b0;
        sw       = '0;
        btn      = '0;
        exp_dir  = 1'b0;
        exp_rot  = 1'b0;
        exp_s0   = 1'b0;
        exp_s1   = 1'b0;
        exp_hi   = 2'd0;
        repeat (10) @(negedge clk_demo);
        arst_n = 1'b1;

        // dark until the first tick
        repeat (TICK_DIV) begin
            @(negedge clk_demo);
            check_value("an", an, 8'hff);
            check_value("led", led, 8'h00);
        end
        check_display(16'h0000, 2'd0);

        for (int b = 4; b > 0; b--) begin
            press_button(b);
            press_button(b);
        end

        repeat (4) begin
            press_button(0);
            check_display(16'h0000, exp_hi);
        end

        sweep_mode(1'b0);
        sweep_mode(1'b1);

        for (int b = 4; b >= 0; b--) begin
            short_pulse(b);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

//--- src.f
source/shifter_pkg.sv
source/tick_gen.sv
source/button_debounce.sv
source/shift_control.sv
source/barrel_shifter.sv
source/seg_display.sv
source/shifter_board_top.sv
dv/shifter_board_tb.sv
